// File: files.f
+incdir+logic
logic/mem_ctrl_pkg.sv
logic/mem_req_decode.sv
logic/mem_line_ctrl.sv
logic/mem_word_result.sv
logic/mem_bridge_top.sv
dv/mem_bridge_checker.sv
dv/mem_bridge_asserts.sv
dv/mem_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --top-module mem_bridge_tb -f files.f -o mem_bridge_sim &&
./obj_dir/mem_bridge_sim | grep "all tests passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }

// File: dv/mem_bridge_tb.sv
// Testbench top with clock, reset, CPU and host models, reference functions, test sequence and watchdog
`include "mem_ctrl_params.svh"

module mem_bridge_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_DELAY = 15;
	// Transactions over all tests
	localparam int N_TX = 29;
	// Per transaction fill, beats, ready delay and handshake slack
	localparam int TIMEOUT_NS = N_TX * (2 * `MC_WORDS + MAX_DELAY + 8) * 10 + 100;

	logic clk;
	logic rst_n;
	logic [1:0] op;
	logic [`MC_ADDR_W-1:0] raw_address;
	logic [`MC_WORD_W-1:0] cpu_wdata;
	logic ready;
	logic [`MC_WORD_W-1:0] cpu_rdata;
	logic rd_valid;
	logic tx_done;
	logic host_init;
	logic host_rd_ready;
	logic host_wr_ready;
	logic [`MC_ADDR_W-1:0] address_offset;
	logic [`MC_LINE_W-1:0] host_rdata;
	logic [`MC_ADDR_W-1:0] host_addr;
	logic [`MC_LINE_W-1:0] host_wdata;
	logic host_rgo;
	logic host_wgo;
	logic host_re;
	logic host_we;
	integer seed = 32'h74b;

	mem_bridge_top dut0 (.*);
	mem_bridge_checker chk0 (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// First written word lands in the lowest word of the line
	function automatic logic [`MC_LINE_W-1:0] expected_line(input logic [`MC_WORD_W-1:0] q[$]);
		logic [`MC_LINE_W-1:0] line;
		line = '0;
		foreach (q[i]) begin
			line[i*`MC_WORD_W +: `MC_WORD_W] = q[i];
		end
		return line;
	endfunction

	function automatic logic [`MC_WORD_W-1:0] expected_word(input logic [`MC_LINE_W-1:0] line,
			input int k);
		return line[k*`MC_WORD_W +: `MC_WORD_W];
	endfunction

	function automatic int rand_delay();
		return $unsigned($random(seed)) % (MAX_DELAY + 1);
	endfunction

	// Inputs change just after the rising edge
	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_accept();
		do @(negedge clk); while (!dut0.req_accept);
		step_cycle();
	endtask

	// CPU goes idle for one cycle after tx_done
	// Host drops its ready levels at the same time
	task automatic wait_done();
		do @(negedge clk); while (!tx_done);
		step_cycle();
		op = 2'd0;
		host_wr_ready = 1'b0;
		host_rd_ready = 1'b0;
		chk0.exp_kind = 2'd0;
		step_cycle();
	endtask

	task automatic do_write(input int delay, input bit move_offset);
		logic [`MC_WORD_W-1:0] q[$];
		logic [`MC_ADDR_W-1:0] addr;
		logic [`MC_ADDR_W-1:0] off;
		addr = $random(seed);
		off = $random(seed);
		for (int k = 0; k < `MC_WORDS; k++) begin
			q.push_back($random(seed));
		end
		chk0.exp_line = expected_line(q);
		chk0.exp_addr = addr + off;
		chk0.exp_kind = 2'd3;
		chk0.exp_tx++;
		op = 2'd3;
		raw_address = addr;
		address_offset = off;
		wait_accept();
		// One word per fill cycle
		for (int k = 0; k < `MC_WORDS; k++) begin
			cpu_wdata = q[k];
			if (k == 3 && move_offset) begin
				address_offset = $random(seed);
			end
			step_cycle();
		end
		repeat (delay) step_cycle();
		host_wr_ready = 1'b1;
		wait_done();
	endtask

	task automatic do_read(input int delay);
		logic [`MC_LINE_W-1:0] line;
		logic [`MC_ADDR_W-1:0] addr;
		logic [`MC_ADDR_W-1:0] off;
		addr = $random(seed);
		off = $random(seed);
		for (int k = 0; k < `MC_WORDS; k++) begin
			line[k*`MC_WORD_W +: `MC_WORD_W] = $random(seed);
			chk0.exp_words[k] = expected_word(line, k);
		end
		chk0.rd_cnt = 0;
		chk0.exp_addr = addr + off;
		chk0.exp_kind = 2'd1;
		chk0.exp_tx++;
		op = 2'd1;
		raw_address = addr;
		address_offset = off;
		// Junk on the bus until the host is ready
		host_rdata = ~line;
		wait_accept();
		repeat (delay) step_cycle();
		host_rdata = line;
		host_rd_ready = 1'b1;
		wait_done();
	endtask

	initial begin
		rst_n = 1'b0;
		op = 2'd0;
		raw_address = '0;
		cpu_wdata = '0;
		host_init = 1'b0;
		host_rd_ready = 1'b0;
		host_wr_ready = 1'b0;
		address_offset = '0;
		host_rdata = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Requests before host_init go nowhere
		chk0.start_test("startup");
		op = 2'd3;
		repeat (6) step_cycle();
		op = 2'd0;
		step_cycle();
		host_init = 1'b1;
		repeat (3) step_cycle();
		chk0.finish_test();

		chk0.start_test("write path");
		do_write(0, 1'b0);
		do_write(2, 1'b1);
		chk0.finish_test();

		chk0.start_test("read path");
		do_read(0);
		do_read(3);
		chk0.finish_test();

		chk0.start_test("back-pressure");
		do_write(rand_delay(), 1'b1);
		do_read(rand_delay());
		do_write(MAX_DELAY, 1'b0);
		do_read(MAX_DELAY);
		chk0.finish_test();

		// Reserved code then idle, then a normal request
		chk0.start_test("reserved op");
		op = 2'd2;
		repeat (8) step_cycle();
		op = 2'd0;
		repeat (2) step_cycle();
		do_write(1, 1'b0);
		chk0.finish_test();

		chk0.start_test("random mix");
		repeat (20) begin
			if ($random(seed) & 1) begin
				do_write(rand_delay(), ($random(seed) & 1) != 0);
			end else begin
				do_read(rand_delay());
			end
		end
		chk0.finish_test();

		chk0.report(dut0.asrt0.fails);
		if (chk0.errors == 0 && dut0.asrt0.fails == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("simulation timed out after %0d ns", TIMEOUT_NS);
		$display("tests failed");
		$finish;
	end

endmodule

// File: dv/mem_bridge_asserts.sv
// Concurrent protocol assertions bound to the bridge top level
module mem_bridge_asserts (
	input logic clk,
	input logic rst_n,
	input logic ready,
	input logic rd_valid,
	input logic host_wgo,
	input logic host_we,
	input logic host_re
);
	timeunit 1ns;
	timeprecision 100ps;

	// Number of failed assertions over the run
	int fails = 0;

	// Host read and write strobes are exclusive
	a_we_re: assert property (@(posedge clk) disable iff (!rst_n) !(host_we && host_re))
		else begin
			$error("host_we and host_re high together");
			fails++;
		end

	// Host write only inside a write request
	a_we_go: assert property (@(posedge clk) disable iff (!rst_n) host_we |-> host_wgo)
		else begin
			$error("host_we without host_wgo");
			fails++;
		end

	// No read words during a host write
	a_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid |-> !(host_wgo || host_we))
		else begin
			$error("rd_valid during a write");
			fails++;
		end

	// Ready never falls again
	a_ready: assert property (@(posedge clk) disable iff (!rst_n) ready |=> ready)
		else begin
			$error("ready fell after rising");
			fails++;
		end

endmodule

bind mem_bridge_top mem_bridge_asserts asrt0 (
	.clk(clk),
	.rst_n(rst_n),
	.ready(ready),
	.rd_valid(rd_valid),
	.host_wgo(host_wgo),
	.host_we(host_we),
	.host_re(host_re)
);

// File: dv/mem_bridge_checker.sv
// Checker module that watches bridge ports, compares with expected values and counts errors per test
`include "mem_ctrl_params.svh"

module mem_bridge_checker (
	input logic clk,
	input logic rst_n,
	input logic ready,
	input logic host_init,
	input logic host_rgo,
	input logic host_wgo,
	input logic host_re,
	input logic host_we,
	input logic host_rd_ready,
	input logic rd_valid,
	input logic tx_done,
	input logic [`MC_WORD_W-1:0] cpu_rdata,
	input logic [`MC_ADDR_W-1:0] host_addr,
	input logic [`MC_LINE_W-1:0] host_wdata
);
	timeunit 1ns;
	timeprecision 100ps;

	int errors = 0;
	int test_errors = 0;
	int tests = 0;
	int tx_seen = 0;
	int exp_tx = 0;
	int rd_cnt = 0;
	// Kind of the running transaction or 0 when nothing may happen
	logic [1:0] exp_kind = 2'd0;
	logic [`MC_LINE_W-1:0] exp_line;
	logic [`MC_ADDR_W-1:0] exp_addr;
	logic [`MC_WORD_W-1:0] exp_words [`MC_WORDS];
	string test_name;
	// Port values seen one cycle earlier
	logic init_prev = 1'b0;
	logic ready_prev = 1'b0;
	logic we_prev = 1'b0;
	logic re_prev = 1'b0;
	logic wgo_prev = 1'b0;
	logic rgo_prev = 1'b0;
	logic rdy_prev = 1'b0;

	task automatic value_error(input string sig, input logic [`MC_LINE_W-1:0] expv,
			input logic [`MC_LINE_W-1:0] actv);
		$display("CHECK FAILED %s expected %h actual %h at %0t", sig, expv, actv, $time);
		errors++;
		test_errors++;
	endtask

	task automatic rule_error(input string what);
		$display("ERROR: %s at %0t", what, $time);
		errors++;
		test_errors++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
		tx_seen = 0;
		exp_tx = 0;
	endtask

	task automatic finish_test();
		if (tx_seen != exp_tx) begin
			rule_error($sformatf("%0d tx_done pulses for %0d transactions", tx_seen, exp_tx));
		end
		tests++;
		if (test_errors == 0) begin
			$display("test %0d %s: ok", tests, test_name);
		end else begin
			$display("test %0d %s: FAILED", tests, test_name);
		end
	endtask

	task automatic report(input int assert_fails);
		$display("%0d tests run, %0d errors, %0d assertion failures", tests, errors,
			assert_fails);
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (!ready && (host_rgo || host_wgo || host_re || host_we)) begin
				rule_error("host activity before ready");
			end
			// Startup timing of ready
			if (!ready && init_prev) begin
				rule_error("ready did not rise after host_init was sampled");
			end
			if (ready && !ready_prev && !init_prev) begin
				rule_error("ready rose without host_init");
			end
			if (exp_kind == 2'd0 && (host_rgo || host_wgo || host_re || host_we
					|| rd_valid || tx_done)) begin
				rule_error("activity without a valid request");
			end
			// Go levels stay up under back-pressure until served
			if (wgo_prev && !host_wgo && !we_prev) begin
				rule_error("host_wgo dropped before host_we");
			end
			if (rgo_prev && !host_rgo && !rdy_prev) begin
				rule_error("host_rgo dropped before host_rd_ready");
			end
			if (host_we && !wgo_prev) begin
				rule_error("host_we without a bubble cycle");
			end
			if (host_rgo && host_rd_ready && host_addr != exp_addr) begin
				value_error("host_addr", `MC_LINE_W'(exp_addr), `MC_LINE_W'(host_addr));
			end
			// Write data and address at the host write
			if (host_we) begin
				if (host_wdata != exp_line) begin
					value_error("host_wdata", exp_line, host_wdata);
				end
				if (host_addr != exp_addr) begin
					value_error("host_addr", `MC_LINE_W'(exp_addr),
						`MC_LINE_W'(host_addr));
				end
			end
			// Read words in order
			if (rd_valid) begin
				if (rd_cnt >= `MC_WORDS) begin
					rule_error("extra rd_valid pulse");
				end else begin
					if (!re_prev) begin
						rule_error("rd_valid without host_re one cycle earlier");
					end
					if (cpu_rdata != exp_words[rd_cnt]) begin
						value_error("cpu_rdata", `MC_LINE_W'(exp_words[rd_cnt]),
							`MC_LINE_W'(cpu_rdata));
					end
				end
				rd_cnt++;
			end
			if (tx_done) begin
				tx_seen++;
				if (exp_kind == 2'd3 && !we_prev) begin
					rule_error("tx_done not one cycle after host_we");
				end
				if (exp_kind == 2'd1 && !(rd_valid && rd_cnt == `MC_WORDS)) begin
					rule_error("tx_done not with the last rd_valid");
				end
			end
		end
		init_prev = host_init;
		ready_prev = ready;
		we_prev = host_we;
		re_prev = host_re;
		wgo_prev = host_wgo;
		rgo_prev = host_rgo;
		rdy_prev = host_rd_ready;
	end

endmodule

// File: logic/mem_bridge_top.sv
// Bridge top level: decode, execute and result stages wired to CPU and host ports
`include "mem_ctrl_params.svh"

module mem_bridge_top (
	input  logic clk,
	input  logic rst_n,
	// CPU side
	input  logic [1:0] op,
	input  logic [`MC_ADDR_W-1:0] raw_address,
	input  logic [`MC_WORD_W-1:0] cpu_wdata,
	output logic ready,
	output logic [`MC_WORD_W-1:0] cpu_rdata,
	output logic rd_valid,
	output logic tx_done,
	// Host side
	input  logic host_init,
	input  logic host_rd_ready,
	input  logic host_wr_ready,
	input  logic [`MC_ADDR_W-1:0] address_offset,
	input  logic [`MC_LINE_W-1:0] host_rdata,
	output logic [`MC_ADDR_W-1:0] host_addr,
	output logic [`MC_LINE_W-1:0] host_wdata,
	output logic host_rgo,
	output logic host_wgo,
	output logic host_re,
	output logic host_we
);
	import mem_ctrl_pkg::*;

	// Decode to execute
	logic req_pending;
	req_kind_e req_kind;
	logic req_accept;
	// Execute to result
	logic beat;
	logic [`MC_WORD_W-1:0] beat_word;
	logic beat_last;
	logic wr_done;

	mem_req_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.op(op),
		.raw_address(raw_address),
		.address_offset(address_offset),
		.req_accept(req_accept),
		.req_pending(req_pending),
		.req_kind(req_kind),
		.host_addr(host_addr)
	);

	mem_line_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.host_init(host_init),
		.host_rd_ready(host_rd_ready),
		.host_wr_ready(host_wr_ready),
		.req_pending(req_pending),
		.req_kind(req_kind),
		.cpu_wdata(cpu_wdata),
		.host_rdata(host_rdata),
		.req_accept(req_accept),
		.ready(ready),
		.host_rgo(host_rgo),
		.host_wgo(host_wgo),
		.host_re(host_re),
		.host_we(host_we),
		.host_wdata(host_wdata),
		.beat(beat),
		.beat_word(beat_word),
		.beat_last(beat_last),
		.wr_done(wr_done)
	);

	mem_word_result u_result (
		.clk(clk),
		.rst_n(rst_n),
		.beat(beat),
		.beat_word(beat_word),
		.beat_last(beat_last),
		.wr_done(wr_done),
		.cpu_rdata(cpu_rdata),
		.rd_valid(rd_valid),
		.tx_done(tx_done)
	);

endmodule

// File: logic/mem_word_result.sv
// Result stage: registered read word, read-valid strobe and transfer-done pulse
`include "mem_ctrl_params.svh"

module mem_word_result (
	input  logic clk,
	input  logic rst_n,
	input  logic beat,
	input  logic [`MC_WORD_W-1:0] beat_word,
	input  logic beat_last,
	input  logic wr_done,
	output logic [`MC_WORD_W-1:0] cpu_rdata,
	output logic rd_valid,
	output logic tx_done
);

	// Done when the last read word goes out
	logic done_next;

	// or one cycle after the host write
	assign done_next = (beat && beat_last) || wr_done;

	// Strobes, one cycle behind execute
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
			tx_done <= 1'b0;
		end else begin
			rd_valid <= beat;
			tx_done <= done_next;
		end
	end

	// Read word, held between beats
	always_ff @(posedge clk) begin
		if (beat) begin
			cpu_rdata <= beat_word;
		end
	end

endmodule

// File: logic/mem_line_ctrl.sv
// Execute stage: controller FSM, fill counter, write bubble and cache line buffer
`include "mem_ctrl_params.svh"

module mem_line_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic host_init,
	input  logic host_rd_ready,
	input  logic host_wr_ready,
	input  logic req_pending,
	input  mem_ctrl_pkg::req_kind_e req_kind,
	input  logic [`MC_WORD_W-1:0] cpu_wdata,
	input  logic [`MC_LINE_W-1:0] host_rdata,
	output logic req_accept,
	output logic ready,
	output logic host_rgo,
	output logic host_wgo,
	output logic host_re,
	output logic host_we,
	output logic [`MC_LINE_W-1:0] host_wdata,
	output logic beat,
	output logic [`MC_WORD_W-1:0] beat_word,
	output logic beat_last,
	output logic wr_done
);
	import mem_ctrl_pkg::*;

	localparam int CNT_W = $clog2(`MC_WORDS);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`MC_WORDS - 1);

	ctrl_state_e state;
	// Word index during fill
	logic [CNT_W-1:0] fill_cnt;
	// One-cycle pause flag
	// Set in the first host op cycle of a write, and left set after completion
	// so the finishing request is not taken again in the tx_done cycle
	logic bubble;
	cache_line_u line_buf;
	// Line buffer enables
	logic load_en;
	logic shift_en;

	// Host side always sees the whole line
	assign host_wdata = line_buf.flat;
	// Word k of the line for the read beat
	assign beat_word = line_buf.words[fill_cnt];

	// Outputs decoded from state, all inactive unless a state sets them
	always_comb begin
		ready = 1'b0;
		req_accept = 1'b0;
		host_rgo = 1'b0;
		host_wgo = 1'b0;
		host_re = 1'b0;
		host_we = 1'b0;
		beat = 1'b0;
		beat_last = 1'b0;
		wr_done = 1'b0;
		load_en = 1'b0;
		shift_en = 1'b0;
		case (state)
			ST_READY: begin
				ready = 1'b1;
				req_accept = req_pending && !bubble;
			end
			ST_HOSTOP: begin
				ready = 1'b1;
				if (req_kind == REQ_WRITE) begin
					host_wgo = 1'b1;
					// Write only after the bubble cycle
					host_we = bubble && host_wr_ready;
					wr_done = bubble && host_wr_ready;
				end else begin
					host_rgo = 1'b1;
					load_en = host_rd_ready;
				end
			end
			ST_FILL: begin
				ready = 1'b1;
				if (req_kind == REQ_WRITE) begin
					shift_en = 1'b1;
				end else begin
					host_re = 1'b1;
					beat = 1'b1;
					beat_last = (fill_cnt == LAST_CNT);
				end
			end
			default: begin
				// Startup, nothing is serviced
			end
		endcase
	end

	// State, counter and bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_STARTUP;
			fill_cnt <= '0;
			bubble <= 1'b0;
		end else begin
			case (state)
				ST_STARTUP: begin
					if (host_init) begin
						state <= ST_READY;
					end
				end
				ST_READY: begin
					// Pause lasts one ready cycle
					bubble <= 1'b0;
					if (req_accept) begin
						state <= (req_kind == REQ_WRITE) ? ST_FILL : ST_HOSTOP;
					end
				end
				ST_HOSTOP: begin
					if (host_we) begin
						// Bubble stays set, blocks the next ready cycle
						state <= ST_READY;
					end else if (host_wgo && !bubble) begin
						bubble <= 1'b1;
					end else if (load_en) begin
						state <= ST_FILL;
					end
				end
				ST_FILL: begin
					if (fill_cnt == LAST_CNT) begin
						fill_cnt <= '0;
						if (req_kind == REQ_WRITE) begin
							state <= ST_HOSTOP;
						end else begin
							state <= ST_READY;
							bubble <= 1'b1;
						end
					end else begin
						fill_cnt <= fill_cnt + 1'b1;
					end
				end
				default: begin
					state <= ST_STARTUP;
				end
			endcase
		end
	end

	// Line buffer: whole line from the host, or CPU words shifted in at the top
	always_ff @(posedge clk) begin
		if (load_en) begin
			line_buf.flat <= host_rdata;
		end else if (shift_en) begin
			for (int i = 0; i < `MC_WORDS - 1; i++) begin
				line_buf.words[i] <= line_buf.words[i+1];
			end
			line_buf.words[`MC_WORDS-1] <= cpu_wdata;
		end
	end

endmodule

// File: logic/mem_req_decode.sv
// Decode stage: op code screening, request kind and corrected host address latch
`include "mem_ctrl_params.svh"

module mem_req_decode (
	input  logic clk,
	input  logic rst_n,
	input  logic [1:0] op,
	input  logic [`MC_ADDR_W-1:0] raw_address,
	input  logic [`MC_ADDR_W-1:0] address_offset,
	input  logic req_accept,
	output logic req_pending,
	output mem_ctrl_pkg::req_kind_e req_kind,
	output logic [`MC_ADDR_W-1:0] host_addr
);
	import mem_ctrl_pkg::*;

	// Op code viewed as a request kind
	req_kind_e op_kind;
	// Kind held for the running transaction
	req_kind_e kind_q;

	assign op_kind = req_kind_e'(op);

	// Only read and write raise a request
	// Idle and the reserved code stay invisible to execute
	assign req_pending = (op_kind == REQ_READ) || (op_kind == REQ_WRITE);

	// Execute picks its next state in the accept cycle itself,
	// so it sees the live kind then and the held copy afterwards
	assign req_kind = req_accept ? op_kind : kind_q;

	// Kind register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			kind_q <= REQ_IDLE;
		end else if (req_accept) begin
			kind_q <= op_kind;
		end
	end

	// Corrected address, fixed for the whole transaction
	// A later offset change does not move it
	always_ff @(posedge clk) begin
		if (req_accept) begin
			host_addr <= raw_address + address_offset;
		end
	end

endmodule

// File: logic/mem_ctrl_pkg.sv
// Package with request kind, controller state and cache line union types
`include "mem_ctrl_params.svh"

package mem_ctrl_pkg;

	// Request kind, same encoding as the CPU op code
	// Code 2 is reserved and never becomes a request
	typedef enum logic [1:0] {
		REQ_IDLE  = 2'b00,
		REQ_READ  = 2'b01,
		REQ_WRITE = 2'b11
	} req_kind_e;

	// Controller states
	typedef enum logic [1:0] {
		ST_STARTUP = 2'b00,
		ST_READY   = 2'b01,
		ST_HOSTOP  = 2'b10,
		ST_FILL    = 2'b11
	} ctrl_state_e;

	// One cache line, seen two ways
	// Flat view for the host bus
	// Word view for the CPU side, element 0 is the least significant word
	typedef union packed {
		logic [`MC_LINE_W-1:0] flat;
		logic [`MC_WORDS-1:0][`MC_WORD_W-1:0] words;
	} cache_line_u;

endpackage

// File: logic/mem_ctrl_params.svh
// Size macros for the memory bridge: word, line and address widths, words per line
`ifndef MEM_CTRL_PARAMS_SVH
`define MEM_CTRL_PARAMS_SVH

// CPU-side word width
`define MC_WORD_W 32

// Host-side cache line width
`define MC_LINE_W 256

// Address width on both sides
`define MC_ADDR_W 32

// CPU words in one cache line
`define MC_WORDS (`MC_LINE_W / `MC_WORD_W)

`endif
